// ==== rtl/xt_bus_pkg.sv ====
/*
 * XT chipset shared types
 * Address, data and bus command formats plus the DMA register port map
 */
package xt_bus_pkg;

    typedef logic [19:0] addr_t;
    typedef logic [7:0]  data_t;

    // One address word, seen as a memory or an I/O address
    typedef union packed {
        struct packed {
            logic [3:0]  page;
            logic [15:0] offset;
        } mem;
        struct packed {
            logic [9:0] unused;
            logic [9:0] port;
        } io;
    } addr_u;

    typedef struct packed {
        addr_u address;
        data_t data;
        logic  io_read;
        logic  io_write;
        logic  mem_read;
        logic  mem_write;
    } bus_cmd_t;

    typedef struct packed {
        logic io_read_n;
        logic io_write_n;
        logic memory_read_n;
        logic memory_write_n;
    } strobe_n_t;

    localparam int DMA_CHANNELS = 4;

    // Low and high address bytes of channel c at 2c and 2c+1
    localparam logic [9:0] DMA_ADDR_BASE = 10'h000;
    localparam logic [9:0] DMA_MODE_PORT = 10'h00B;
    localparam logic [9:0] DMA_PAGE_BASE = 10'h080;

endpackage

// ==== rtl/cpu_bus_cycle.sv ====
/*
 * CPU bus-cycle unit
 * Decodes 8088 status into bus commands, pulses ALE and latches the address
 */
`timescale 1ns/1ps

module cpu_bus_cycle
    import xt_bus_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic [2:0] processor_status,
    input  addr_t      cpu_address,
    input  data_t      cpu_data,
    input  logic       cpu_grant,
    input  logic       bus_done,
    output bus_cmd_t   cpu_cmd,
    output logic       cpu_pending,
    output logic       address_latch_enable,
    output logic       processor_ready
);

    typedef enum logic [1:0] {
        CPU_IDLE,
        CPU_ALE,
        CPU_CMD,
        CPU_PASSIVE
    } cpu_state_t;

    cpu_state_t state;
    addr_t      addr_q;
    data_t      data_q;
    logic [3:0] kind;
    logic [3:0] kind_q;
    logic       cycle_request;

    // Command order is io_read, io_write, mem_read, mem_write
    always_comb
    begin
        case (processor_status)
            3'b001:  kind = 4'b1000;
            3'b010:  kind = 4'b0100;
            3'b100:  kind = 4'b0010;  // code fetch
            3'b101:  kind = 4'b0010;
            3'b110:  kind = 4'b0001;
            default: kind = 4'b0000;  // INTA, halt and passive
        endcase
    end

    assign cycle_request = |kind;

    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
        begin
            state  <= CPU_IDLE;
            kind_q <= 4'b0000;
        end
        else
        begin
            case (state)
                CPU_IDLE:
                    if (cycle_request && cpu_grant)
                    begin
                        state  <= CPU_ALE;
                        kind_q <= kind;
                    end
                CPU_ALE:
                    state <= CPU_CMD;
                CPU_CMD:
                    if (bus_done)
                        state <= CPU_PASSIVE;
                default:
                    if (processor_status == 3'b111)
                        state <= CPU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if (state == CPU_IDLE && cycle_request && cpu_grant)
        begin
            addr_q <= cpu_address;
            data_q <= cpu_data;
        end
    end

    always_comb
    begin
        cpu_cmd.address = addr_q;
        cpu_cmd.data    = data_q;
        {cpu_cmd.io_read, cpu_cmd.io_write, cpu_cmd.mem_read, cpu_cmd.mem_write} =
            kind_q & {4{state == CPU_CMD}};
    end

    assign cpu_pending = (state == CPU_IDLE && cycle_request) ||
                         state == CPU_ALE || state == CPU_CMD;
    assign address_latch_enable = (state == CPU_ALE);
    assign processor_ready      = (state == CPU_CMD) && bus_done;

endmodule

// ==== rtl/dma_channels.sv ====
/*
 * DMA unit
 * Request latching with timer-driven refresh on channel 0, per-channel
 * address, page and mode registers, and transfer commands
 */
`timescale 1ns/1ps

module dma_channels
    import xt_bus_pkg::*;
#(
    parameter int DMA_CHANNELS = xt_bus_pkg::DMA_CHANNELS
)
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic [DMA_CHANNELS-1:1] dma_request,
    input  logic                    timer_channel1,
    input  bus_cmd_t                cpu_cmd,
    input  logic                    bus_done,
    input  logic [DMA_CHANNELS-1:0] dma_grant,
    output logic                    dma_hold,
    output bus_cmd_t                dma_cmd,
    output data_t                   reg_data,
    output logic                    reg_hit
);

    logic                    timer_prev;
    logic                    refresh_req;
    logic [DMA_CHANNELS-1:0] dma_req;
    logic [15:0]             chan_addr [DMA_CHANNELS];
    logic [3:0]              chan_page [DMA_CHANNELS];
    logic [DMA_CHANNELS-1:0] mode;
    logic [9:0]              port;
    logic                    port_hit;
    logic                    cpu_wr;

    // Refresh request on the rising edge of timer channel 1
    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
        begin
            timer_prev  <= 1'b1;
            refresh_req <= 1'b0;
        end
        else
        begin
            timer_prev <= timer_channel1;
            if (dma_grant[0])
                refresh_req <= 1'b0;
            else if (timer_channel1 && !timer_prev)
                refresh_req <= 1'b1;
        end
    end

    assign dma_req  = {dma_request, refresh_req};
    assign dma_hold = |dma_req;

    assign port   = cpu_cmd.address.io.port;
    assign cpu_wr = bus_done && cpu_cmd.io_write;

    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
        begin
            for (int c = 0; c < DMA_CHANNELS; c++)
            begin
                chan_addr[c] <= 16'h0000;
                chan_page[c] <= 4'h0;
            end
            mode <= '0;
        end
        else if (bus_done)
        begin
            for (int c = 0; c < DMA_CHANNELS; c++)
            begin
                if (dma_grant[c])
                    chan_addr[c] <= chan_addr[c] + 16'd1;
                if (cpu_wr && port == DMA_ADDR_BASE + 10'(2 * c))
                    chan_addr[c][7:0] <= cpu_cmd.data;
                if (cpu_wr && port == DMA_ADDR_BASE + 10'(2 * c + 1))
                    chan_addr[c][15:8] <= cpu_cmd.data;
                if (cpu_wr && port == DMA_PAGE_BASE + 10'(c))
                    chan_page[c] <= cpu_cmd.data[3:0];
            end
            if (cpu_wr && port == DMA_MODE_PORT)
                mode <= cpu_cmd.data[DMA_CHANNELS-1:0];
        end
    end

    // Register read-back
    always_comb
    begin
        port_hit = 1'b0;
        reg_data = '0;
        if (port == DMA_MODE_PORT)
        begin
            port_hit = 1'b1;
            reg_data = data_t'(mode);
        end
        for (int c = 0; c < DMA_CHANNELS; c++)
        begin
            if (port == DMA_ADDR_BASE + 10'(2 * c))
            begin
                port_hit = 1'b1;
                reg_data = chan_addr[c][7:0];
            end
            if (port == DMA_ADDR_BASE + 10'(2 * c + 1))
            begin
                port_hit = 1'b1;
                reg_data = chan_addr[c][15:8];
            end
            if (port == DMA_PAGE_BASE + 10'(c))
            begin
                port_hit = 1'b1;
                reg_data = {4'h0, chan_page[c]};
            end
        end
    end

    assign reg_hit = port_hit && cpu_cmd.io_read;

    // Data field carries the request lines to the arbiter
    always_comb
    begin
        dma_cmd      = '0;
        dma_cmd.data = data_t'(dma_req);
        for (int c = 0; c < DMA_CHANNELS; c++)
        begin
            if (dma_grant[c])
            begin
                dma_cmd.address.mem.page   = chan_page[c];
                dma_cmd.address.mem.offset = chan_addr[c];
                dma_cmd.io_read            = mode[c];
                dma_cmd.mem_write          = mode[c];
                dma_cmd.io_write           = !mode[c];
                dma_cmd.mem_read           = !mode[c];
            end
        end
    end

endmodule

// ==== rtl/system_bus_arbiter.sv ====
/*
 * System bus arbiter
 * Shares the bus between CPU and DMA, drives the pins, returns read data
 */
`timescale 1ns/1ps

module system_bus_arbiter
    import xt_bus_pkg::*;
#(
    parameter int DMA_CHANNELS = xt_bus_pkg::DMA_CHANNELS
)
(
    input  logic                    clock,
    input  logic                    reset,
    input  bus_cmd_t                cpu_cmd,
    input  bus_cmd_t                dma_cmd,
    input  logic                    cpu_pending,
    input  logic                    dma_hold,
    input  logic                    bus_done,
    input  logic                    reg_hit,
    input  data_t                   reg_data,
    input  data_t                   data_bus_ext,
    output logic                    cpu_grant,
    output logic [DMA_CHANNELS-1:0] dma_grant,
    output logic [DMA_CHANNELS-1:0] dma_acknowledge_n,
    output logic                    address_enable_n,
    output addr_t                   address,
    output data_t                   data_bus,
    output logic                    data_bus_direction,
    output strobe_n_t               strobes,
    output bus_cmd_t                bus_cmd,
    output data_t                   cpu_read_data
);

    typedef enum logic [1:0] {
        ARB_CPU,
        ARB_SETUP,
        ARB_XFER,
        ARB_END
    } arb_state_t;

    arb_state_t              state;
    logic [DMA_CHANNELS-1:0] req;
    logic [DMA_CHANNELS-1:0] first_req;
    logic [DMA_CHANNELS-1:0] grant_q;
    logic                    cpu_read;
    data_t                   read_sel;
    data_t                   read_q;

    // Lowest requesting channel
    assign req       = dma_cmd.data[DMA_CHANNELS-1:0];
    assign first_req = req & (~req + 1'b1);

    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
        begin
            state   <= ARB_CPU;
            grant_q <= '0;
        end
        else
        begin
            case (state)
                ARB_CPU:
                    if (dma_hold && !cpu_pending)
                    begin
                        state   <= ARB_SETUP;
                        grant_q <= first_req;
                    end
                ARB_SETUP:
                    state <= ARB_XFER;
                ARB_XFER:
                    if (bus_done)
                        state <= ARB_END;
                default:
                begin
                    state   <= ARB_CPU;
                    grant_q <= '0;
                end
            endcase
        end
    end

    assign cpu_grant         = (state == ARB_CPU);
    assign dma_grant         = grant_q;
    assign dma_acknowledge_n = ~grant_q;
    assign address_enable_n  = (state == ARB_CPU);

    // DMA strobes only in the transfer phase
    always_comb
    begin
        if (state == ARB_CPU)
            bus_cmd = cpu_cmd;
        else
        begin
            bus_cmd = dma_cmd;
            if (state != ARB_XFER)
                {bus_cmd.io_read, bus_cmd.io_write, bus_cmd.mem_read, bus_cmd.mem_write} = '0;
        end
    end

    assign address                = bus_cmd.address;
    assign data_bus               = cpu_cmd.data;
    assign data_bus_direction     = cpu_grant && (cpu_cmd.io_write || cpu_cmd.mem_write);
    assign strobes.io_read_n      = !bus_cmd.io_read;
    assign strobes.io_write_n     = !bus_cmd.io_write;
    assign strobes.memory_read_n  = !bus_cmd.mem_read;
    assign strobes.memory_write_n = !bus_cmd.mem_write;

    assign cpu_read = cpu_grant && bus_done && (cpu_cmd.io_read || cpu_cmd.mem_read);
    assign read_sel = reg_hit ? reg_data : data_bus_ext;

    always_ff @(posedge clock)
    begin
        if (cpu_read)
            read_q <= read_sel;
    end

    // Valid in the ready cycle, then held
    assign cpu_read_data = cpu_read ? read_sel : read_q;

endmodule

// ==== rtl/wait_state_gen.sv ====
/*
 * Wait-state generator
 * Times each active bus command and stretches it while the channel is not ready
 */
`timescale 1ns/1ps

module wait_state_gen
    import xt_bus_pkg::*;
#(
    parameter int IO_WAIT_STATES = 1
)
(
    input  logic     clock,
    input  logic     reset,
    input  bus_cmd_t bus_cmd,
    input  logic     io_channel_ready,
    output logic     cycle_end
);

    localparam int CW = $clog2(IO_WAIT_STATES + 3);

    logic [1:0]    ready_sync;
    logic          active;
    logic          io_cycle;
    logic [CW-1:0] count;
    logic [CW-1:0] last_count;

    assign active   = bus_cmd.io_read || bus_cmd.io_write ||
                      bus_cmd.mem_read || bus_cmd.mem_write;
    assign io_cycle = bus_cmd.io_read || bus_cmd.io_write;

    // Memory strobes last two clocks, I/O adds the wait states
    assign last_count = io_cycle ? CW'(IO_WAIT_STATES + 1) : CW'(1);
    assign cycle_end  = active && (count >= last_count) && ready_sync[1];

    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
        begin
            ready_sync <= 2'b00;
            count      <= '0;
        end
        else
        begin
            ready_sync <= {ready_sync[0], io_channel_ready};
            if (!active || cycle_end)
                count <= '0;
            else if (count < last_count)
                count <= count + 1'b1;
        end
    end

endmodule

// ==== rtl/xt_chipset_top.sv ====
/*
 * XT chipset system-bus core
 * CPU and DMA peers on one arbitrated bus, cycles ended by the wait-state generator
 */
`timescale 1ns/1ps

module xt_chipset_top
    import xt_bus_pkg::*;
#(
    parameter int IO_WAIT_STATES = 1
)
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic [2:0]              processor_status,
    input  addr_t                   cpu_address,
    input  data_t                   cpu_data,
    input  data_t                   data_bus_ext,
    input  logic                    io_channel_ready,
    input  logic [DMA_CHANNELS-1:1] dma_request,
    input  logic                    timer_channel1,
    output addr_t                   address,
    output data_t                   data_bus,
    output logic                    data_bus_direction,
    output logic                    address_latch_enable,
    output strobe_n_t               strobes,
    output logic                    address_enable_n,
    output logic [DMA_CHANNELS-1:0] dma_acknowledge_n,
    output logic                    processor_ready,
    output data_t                   cpu_read_data
);

    bus_cmd_t                cpu_cmd;
    bus_cmd_t                dma_cmd;
    bus_cmd_t                bus_cmd;
    logic                    cpu_pending;
    logic                    dma_hold;
    logic                    cpu_grant;
    logic [DMA_CHANNELS-1:0] dma_grant;
    logic                    bus_done;
    logic                    reg_hit;
    data_t                   reg_data;

    cpu_bus_cycle cpu_bus_cycle_inst (
        .clock                (clock),
        .reset                (reset),
        .processor_status     (processor_status),
        .cpu_address          (cpu_address),
        .cpu_data             (cpu_data),
        .cpu_grant            (cpu_grant),
        .bus_done             (bus_done),
        .cpu_cmd              (cpu_cmd),
        .cpu_pending          (cpu_pending),
        .address_latch_enable (address_latch_enable),
        .processor_ready      (processor_ready)
    );

    dma_channels #(
        .DMA_CHANNELS (DMA_CHANNELS)
    ) dma_channels_inst (
        .clock          (clock),
        .reset          (reset),
        .dma_request    (dma_request),
        .timer_channel1 (timer_channel1),
        .cpu_cmd        (cpu_cmd),
        .bus_done       (bus_done),
        .dma_grant      (dma_grant),
        .dma_hold       (dma_hold),
        .dma_cmd        (dma_cmd),
        .reg_data       (reg_data),
        .reg_hit        (reg_hit)
    );

    system_bus_arbiter #(
        .DMA_CHANNELS (DMA_CHANNELS)
    ) system_bus_arbiter_inst (
        .clock              (clock),
        .reset              (reset),
        .cpu_cmd            (cpu_cmd),
        .dma_cmd            (dma_cmd),
        .cpu_pending        (cpu_pending),
        .dma_hold           (dma_hold),
        .bus_done           (bus_done),
        .reg_hit            (reg_hit),
        .reg_data           (reg_data),
        .data_bus_ext       (data_bus_ext),
        .cpu_grant          (cpu_grant),
        .dma_grant          (dma_grant),
        .dma_acknowledge_n  (dma_acknowledge_n),
        .address_enable_n   (address_enable_n),
        .address            (address),
        .data_bus           (data_bus),
        .data_bus_direction (data_bus_direction),
        .strobes            (strobes),
        .bus_cmd            (bus_cmd),
        .cpu_read_data      (cpu_read_data)
    );

    wait_state_gen #(
        .IO_WAIT_STATES (IO_WAIT_STATES)
    ) wait_state_gen_inst (
        .clock            (clock),
        .reset            (reset),
        .bus_cmd          (bus_cmd),
        .io_channel_ready (io_channel_ready),
        .cycle_end        (bus_done)
    );

endmodule

// ==== tests/xt_chipset_chk.sv ====
/*
 * Bus pin checks for the XT chipset, bound into the top level
 */
`timescale 1ns/1ps

module xt_chipset_chk
    import xt_bus_pkg::*;
(
    input logic                    clock,
    input logic                    reset,
    input logic                    address_latch_enable,
    input logic                    address_enable_n,
    input logic [DMA_CHANNELS-1:0] dma_acknowledge_n,
    input strobe_n_t               strobes
);

    ale_single_cycle: assert property (@(posedge clock) disable iff (reset)
        address_latch_enable |=> !address_latch_enable)
        else $error("address_latch_enable high for more than one cycle");

    one_acknowledge: assert property (@(posedge clock) disable iff (reset)
        $onehot0(~dma_acknowledge_n))
        else $error("more than one DMA acknowledge low");

    aen_with_acknowledge: assert property (@(posedge clock) disable iff (reset)
        !address_enable_n |-> $onehot(~dma_acknowledge_n))
        else $error("address_enable_n low without exactly one acknowledge");

    io_strobes_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(!strobes.io_read_n && !strobes.io_write_n))
        else $error("I/O read and write strobes low together");

endmodule

bind xt_chipset_top xt_chipset_chk xt_chipset_chk_inst (
    .clock                (clock),
    .reset                (reset),
    .address_latch_enable (address_latch_enable),
    .address_enable_n     (address_enable_n),
    .dma_acknowledge_n    (dma_acknowledge_n),
    .strobes              (strobes)
);

// ==== tests/tb_xt_chipset.sv ====
/*
 * Testbench for the XT chipset bus core
 * Directed CPU cycles, DMA register access, DMA transfers and refresh arbitration
 */
`timescale 1ns/1ps

module tb_xt_chipset
    import xt_bus_pkg::*;
();

    // About 45 bus cycles of under 10 clocks each, with wide margin
    localparam int MAX_CYCLES = 2000;
    localparam strobe_n_t STROBES_IDLE = '1;

    logic                    clock;
    logic                    reset;
    logic [2:0]              processor_status;
    addr_t                   cpu_address;
    data_t                   cpu_data;
    data_t                   data_bus_ext;
    logic                    io_channel_ready;
    logic [DMA_CHANNELS-1:1] dma_request;
    logic                    timer_channel1;
    addr_t                   address;
    data_t                   data_bus;
    logic                    data_bus_direction;
    logic                    address_latch_enable;
    strobe_n_t               strobes;
    logic                    address_enable_n;
    logic [DMA_CHANNELS-1:0] dma_acknowledge_n;
    logic                    processor_ready;
    data_t                   cpu_read_data;
    int                      error_count = 0;
    int                      cycle_count = 0;

    xt_chipset_top #(
        .IO_WAIT_STATES (1)
    ) xt_chipset_top_inst (.*);

    initial
        clock = 1'b0;

    always #2 clock = ~clock;

    always @(posedge clock)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout: no result after %0d clock cycles", cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp)
        begin
            error_count++;
            $display("FAIL @%0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp)
        begin
            error_count++;
            $display("FAIL @%0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_strobes(input strobe_n_t got, input strobe_n_t exp, input string what);
        if (got !== exp)
        begin
            error_count++;
            $display("FAIL @%0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            error_count++;
            $display("FAIL @%0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // One CPU bus cycle; stall holds the channel not ready for that many clocks after ALE
    task automatic cpu_cycle(input logic [2:0] status, input addr_t addr, input data_t wdata,
                             input int stall, output data_t rdata, output int strobe_len);
        strobe_n_t exp_strobes;
        logic      is_write;
        int        stall_left;
        exp_strobes = STROBES_IDLE;
        case (status)
            3'b001:  exp_strobes.io_read_n = 1'b0;
            3'b010:  exp_strobes.io_write_n = 1'b0;
            3'b110:  exp_strobes.memory_write_n = 1'b0;
            default: exp_strobes.memory_read_n = 1'b0;
        endcase
        is_write = (status == 3'b010 || status == 3'b110);
        stall_left = 0;
        strobe_len = 0;
        processor_status = status;
        cpu_address = addr;
        cpu_data = wdata;
        do
        begin
            @(negedge clock);
            if (stall_left > 0)
            begin
                stall_left--;
                if (stall_left == 0)
                    io_channel_ready = 1'b1;
            end
            if (address_latch_enable)
            begin
                check_addr(address, addr, "address at ALE");
                if (stall > 0)
                begin
                    io_channel_ready = 1'b0;
                    stall_left = stall;
                end
            end
            if (!(&strobes))
            begin
                strobe_len++;
                check_strobes(strobes, exp_strobes, "CPU strobes");
                check_flag(data_bus_direction, is_write, "data_bus_direction in CPU cycle");
                if (is_write)
                    check_data(data_bus, wdata, "write data on the bus");
            end
        end
        while (!processor_ready);
        rdata = cpu_read_data;
        @(negedge clock);
        check_strobes(strobes, STROBES_IDLE, "strobes after processor_ready");
        processor_status = 3'b111;
        @(negedge clock);
    endtask

    task automatic io_write(input logic [9:0] port, input data_t value);
        data_t unused_read;
        int    len;
        cpu_cycle(3'b010, addr_t'(port), value, 0, unused_read, len);
    endtask

    task automatic io_read(input logic [9:0] port, output data_t value);
        int len;
        cpu_cycle(3'b001, addr_t'(port), 8'h00, 0, value, len);
    endtask

    task automatic program_channel(input int c, input logic [15:0] offset, input logic [3:0] page);
        io_write(DMA_ADDR_BASE + 10'(2 * c), offset[7:0]);
        io_write(DMA_ADDR_BASE + 10'(2 * c + 1), offset[15:8]);
        io_write(DMA_PAGE_BASE + 10'(c), {4'h0, page});
    endtask

    // Follows one DMA transfer of a channel from acknowledge to release
    task automatic dma_transfer(input int chan, input addr_t exp_addr, input logic to_memory);
        strobe_n_t exp_strobes;
        int        len;
        exp_strobes.io_read_n      = !to_memory;
        exp_strobes.io_write_n     = to_memory;
        exp_strobes.memory_read_n  = to_memory;
        exp_strobes.memory_write_n = !to_memory;
        len = 0;
        do
            @(negedge clock);
        while (dma_acknowledge_n[chan]);
        check_flag(address_enable_n, 1'b0, "address_enable_n with acknowledge");
        check_addr(address, exp_addr, "DMA address");
        check_strobes(strobes, STROBES_IDLE, "strobes in DMA setup");
        @(negedge clock);
        while (!(&strobes))
        begin
            check_strobes(strobes, exp_strobes, "DMA strobes");
            check_flag(data_bus_direction, 1'b0, "data_bus_direction in DMA transfer");
            len++;
            @(negedge clock);
        end
        check_data(data_t'(len), 8'd3, "DMA strobe cycles");
        check_flag(dma_acknowledge_n[chan], 1'b0, "acknowledge after strobes");
        @(negedge clock);
        check_flag(dma_acknowledge_n[chan], 1'b1, "acknowledge released");
        check_flag(address_enable_n, 1'b1, "address_enable_n released");
    endtask

    task automatic reset_values();
        data_t got;
        check_strobes(strobes, STROBES_IDLE, "strobes after reset");
        check_flag(address_enable_n, 1'b1, "address_enable_n after reset");
        check_flag(&dma_acknowledge_n, 1'b1, "acknowledges after reset");
        check_flag(address_latch_enable, 1'b0, "address_latch_enable after reset");
        check_flag(processor_ready, 1'b0, "processor_ready after reset");
        data_bus_ext = 8'hFF;
        io_read(DMA_MODE_PORT, got);
        check_data(got, 8'h00, "mode register after reset");
        io_read(DMA_PAGE_BASE, got);
        check_data(got, 8'h00, "page register after reset");
        data_bus_ext = '0;
    endtask

    task automatic memory_write();
        addr_t addr;
        data_t value;
        data_t unused_read;
        int    len;
        addr = addr_t'($urandom);
        value = data_t'($urandom);
        cpu_cycle(3'b110, addr, value, 0, unused_read, len);
        check_data(data_t'(len), 8'd2, "memory write strobe cycles");
    endtask

    task automatic io_read_external();
        addr_t addr;
        data_t ext;
        data_t got;
        int    len;
        // Ports 0x100 and up are clear of the DMA registers
        addr = addr_t'(10'h100 + 10'($urandom_range(32'h2FF)));
        ext = data_t'($urandom);
        data_bus_ext = ext;
        cpu_cycle(3'b001, addr, 8'h00, 0, got, len);
        check_data(data_t'(len), 8'd3, "I/O read strobe cycles");
        check_data(got, ext, "I/O read data");
        ext = data_t'($urandom);
        data_bus_ext = ext;
        cpu_cycle(3'b001, addr, 8'h00, 4, got, len);
        check_flag(len >= 4, 1'b1, "stalled I/O strobe of at least 4 cycles");
        check_data(got, ext, "stalled I/O read data");
    endtask

    task automatic dma_register_readback();
        logic [9:0] port;
        data_t      value;
        data_t      expected;
        data_t      got;
        for (int i = 0; i < 13; i++)
        begin
            if (i < 8)
                port = DMA_ADDR_BASE + 10'(i);
            else if (i < 12)
                port = DMA_PAGE_BASE + 10'(i - 8);
            else
                port = DMA_MODE_PORT;
            value = data_t'($urandom);
            // Page and mode registers hold the low nibble only
            expected = (i < 8) ? value : {4'h0, value[3:0]};
            io_write(port, value);
            data_bus_ext = ~expected;
            io_read(port, got);
            check_data(got, expected, "DMA register read-back");
        end
        data_bus_ext = '0;
    endtask

    task automatic channel2_transfers();
        logic [15:0] offset;
        logic [3:0]  page;
        offset = 16'($urandom);
        page = 4'($urandom);
        program_channel(2, offset, page);
        io_write(DMA_MODE_PORT, 8'h04);
        dma_request[2] = 1'b1;
        dma_transfer(2, {page, offset}, 1'b1);
        dma_transfer(2, {page, offset + 16'd1}, 1'b1);
        dma_request = '0;
    endtask

    task automatic refresh_arbitration();
        logic [15:0] offset0;
        logic [15:0] offset3;
        logic [3:0]  page0;
        logic [3:0]  page3;
        offset0 = 16'($urandom);
        offset3 = 16'($urandom);
        page0 = 4'($urandom);
        page3 = 4'($urandom);
        program_channel(0, offset0, page0);
        program_channel(3, offset3, page3);
        io_write(DMA_MODE_PORT, 8'h08);
        timer_channel1 = 1'b1;
        @(negedge clock);
        // Channel 3 joins once the refresh request is latched
        dma_request[3] = 1'b1;
        dma_transfer(0, {page0, offset0}, 1'b0);
        dma_transfer(3, {page3, offset3}, 1'b1);
        dma_request = '0;
        repeat (10)
        begin
            @(negedge clock);
            check_flag(&dma_acknowledge_n, 1'b1, "acknowledges without a timer edge");
        end
        timer_channel1 = 1'b0;
        @(negedge clock);
        timer_channel1 = 1'b1;
        dma_transfer(0, {page0, offset0 + 16'd1}, 1'b0);
    endtask

    initial
    begin
        void'($urandom(32'hbf55_12c9));
        reset = 1'b1;
        processor_status = 3'b111;
        cpu_address = '0;
        cpu_data = '0;
        data_bus_ext = '0;
        io_channel_ready = 1'b1;
        dma_request = '0;
        timer_channel1 = 1'b0;
        repeat (5) @(negedge clock);
        reset = 1'b0;
        reset_values();
        memory_write();
        io_read_external();
        dma_register_readback();
        channel2_transfers();
        refresh_arbitration();
        repeat (4) @(negedge clock);
        $display("Checks complete with %0d errors", error_count);
        if (error_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/xt_bus_pkg.sv
rtl/cpu_bus_cycle.sv
rtl/dma_channels.sv
rtl/system_bus_arbiter.sv
rtl/wait_state_gen.sv
rtl/xt_chipset_top.sv
tests/xt_chipset_chk.sv
tests/tb_xt_chipset.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the XT chipset testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_xt_chipset \
    -f flist.f -o sim_xt_chipset || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_xt_chipset > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1
